/* hw/fe_pkg.sv */
// shared widths, types and branch-kind codes for the fetch front end
// compile this first, every RTL file refers to it
`default_nettype none

package fe_pkg;

  // addresses
  localparam int ADDR_W = 32;
  typedef logic [ADDR_W-1:0] addr_t;

  // one fetch block per request
  localparam int FETCH_BYTES = 32;
  localparam int BLOCK_OFS_W = $clog2(FETCH_BYTES);

  // global branch history, newest outcome in bit 0
  localparam int HIST_W = 16;
  typedef logic [HIST_W-1:0] ghist_t;

  // branch kind as recorded in the BTB
  typedef logic [1:0] kind_t;

  localparam kind_t KIND_COND = 2'd0;
  localparam kind_t KIND_JUMP = 2'd1;
  localparam kind_t KIND_CALL = 2'd2;
  localparam kind_t KIND_RET  = 2'd3;

  // retire-time condition code and flags
  typedef logic [3:0] cond_t;
  typedef logic [3:0] flags_t;

  // flag bit positions
  localparam int FLAG_C = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_S = 1;
  localparam int FLAG_V = 0;

endpackage

`default_nettype wire

/* hw/branch_retire.sv */
// resolves one retired branch per cycle against its flags
// registers the BTB update, the counter training and any redirect,
// all valid one cycle after ret_valid
`timescale 1ns/1ns
`default_nettype none

module branch_retire (
  input  logic           clk,
  input  logic           rst,
  input  logic           ret_valid,
  input  fe_pkg::addr_t  ret_src,
  input  fe_pkg::addr_t  ret_target,
  input  fe_pkg::kind_t  ret_kind,
  input  fe_pkg::cond_t  ret_cond,
  input  fe_pkg::flags_t ret_flags,
  input  logic           ret_pred_taken,
  input  fe_pkg::addr_t  ret_pred_target,
  input  fe_pkg::ghist_t ret_ghist,
  output logic           upd_valid,
  output logic           trn_valid,
  output fe_pkg::addr_t  upd_src,
  output fe_pkg::addr_t  upd_target,
  output fe_pkg::kind_t  upd_kind,
  output fe_pkg::ghist_t upd_ghist,
  output logic           upd_taken,
  output logic           redirect_valid,
  output fe_pkg::addr_t  redirect_adr,
  output fe_pkg::ghist_t redirect_ghist
);

  logic is_cond;
  logic taken;
  logic mispred;

  // bits 3:1 pick the base test, bit 0 inverts it
  function automatic logic cond_holds(fe_pkg::cond_t c, fe_pkg::flags_t f);
    logic cf, zf, sf, vf;
    logic base;
    cf = f[fe_pkg::FLAG_C];
    zf = f[fe_pkg::FLAG_Z];
    sf = f[fe_pkg::FLAG_S];
    vf = f[fe_pkg::FLAG_V];
    case (c[3:1])
      3'd0:    base = 1'b1;
      3'd1:    base = zf;
      3'd2:    base = cf;
      3'd3:    base = sf;
      3'd4:    base = vf;
      3'd5:    base = sf ^ vf;          // signed less
      3'd6:    base = (sf ^ vf) | zf;   // signed less or equal
      default: base = cf | zf;          // unsigned below or equal
    endcase
    return base ^ c[0];
  endfunction

  assign is_cond = (ret_kind == fe_pkg::KIND_COND);
  assign taken   = !is_cond || cond_holds(ret_cond, ret_flags);
  assign mispred = (taken != ret_pred_taken) || (taken && ret_target != ret_pred_target);

  always_ff @(posedge clk) begin
    if (rst) begin
      upd_valid      <= 1'b0;
      trn_valid      <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      upd_valid      <= ret_valid;
      trn_valid      <= ret_valid && is_cond;
      redirect_valid <= ret_valid && mispred;
    end
  end

  always_ff @(posedge clk) begin
    if (ret_valid) begin
      upd_src    <= ret_src;
      upd_target <= ret_target;
      upd_kind   <= ret_kind;
      upd_ghist  <= ret_ghist;   // history seen at predict time
      upd_taken  <= taken;
      redirect_adr <= taken ? ret_target : ret_src + fe_pkg::addr_t'(fe_pkg::FETCH_BYTES);
      redirect_ghist <= is_cond ? {ret_ghist[fe_pkg::HIST_W-2:0], taken} : ret_ghist;
    end
  end

  // retire reports whole fetch-block addresses
  a_src_block: assert property (@(posedge clk) disable iff (rst)
    ret_valid |-> (ret_src[fe_pkg::BLOCK_OFS_W-1:0] == '0));

endmodule

`default_nettype wire

/* hw/dir_predictor.sv */
// direction predictor, three tables of 2-bit counters
// each table hashes the block address with a different history length,
// the prediction is the majority of the three upper bits
// after reset the tables are swept to weakly not taken, 2^PHT_IDX_W cycles
`timescale 1ns/1ns
`default_nettype none

module dir_predictor #(
  parameter int PHT_IDX_W = 8
) (
  input  logic           clk,
  input  logic           rst,
  input  fe_pkg::addr_t  lk_adr,
  input  fe_pkg::ghist_t lk_ghist,
  input  logic           trn_valid,
  input  fe_pkg::addr_t  upd_src,
  input  fe_pkg::ghist_t upd_ghist,
  input  logic           upd_taken,
  output logic           pred_taken
);

  localparam int ENTRIES = 1 << PHT_IDX_W;

  typedef logic [PHT_IDX_W-1:0] idx_t;

  idx_t       sweep_idx;
  logic       sweep_busy;
  logic [2:0] vote;

  // block bits xor the low hist_len history bits, folded to index width
  function automatic idx_t hash(fe_pkg::addr_t adr, fe_pkg::ghist_t h, int hist_len);
    idx_t r;
    r = adr[fe_pkg::BLOCK_OFS_W +: PHT_IDX_W];
    for (int i = 0; i < fe_pkg::HIST_W; i++) begin
      if (i < hist_len) r[i % PHT_IDX_W] = r[i % PHT_IDX_W] ^ h[i];
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_idx  <= '0;
      sweep_busy <= 1'b1;
    end else if (sweep_busy) begin
      sweep_idx <= sweep_idx + 1'b1;
      if (&sweep_idx) sweep_busy <= 1'b0;   // last entry written
    end
  end

  for (genvar t = 0; t < 3; t++) begin : g_tbl
    localparam int HLEN = (t == 0) ? 2 : (t == 1) ? 8 : fe_pkg::HIST_W;

    logic [1:0] ctr [ENTRIES];
    idx_t       lk_idx;
    idx_t       tr_idx;
    logic [1:0] tr_old;

    assign lk_idx  = hash(lk_adr, lk_ghist, HLEN);
    assign tr_idx  = hash(upd_src, upd_ghist, HLEN);
    assign tr_old  = ctr[tr_idx];
    assign vote[t] = ctr[lk_idx][1];

    always_ff @(posedge clk) begin
      if (sweep_busy) begin
        ctr[sweep_idx] <= 2'b01;   // weakly not taken
      end else if (trn_valid) begin
        if (upd_taken && tr_old != 2'b11) begin
          ctr[tr_idx] <= tr_old + 2'b01;
        end else if (!upd_taken && tr_old != 2'b00) begin
          ctr[tr_idx] <= tr_old - 2'b01;
        end
      end
    end
  end

  assign pred_taken = !sweep_busy &&
                      ((vote[0] && vote[1]) || (vote[0] && vote[2]) || (vote[1] && vote[2]));

endmodule

`default_nettype wire

/* hw/target_buffer.sv */
// direct-mapped branch target buffer
// combinational lookup on the fetch address, written by retire updates
`timescale 1ns/1ns
`default_nettype none

module target_buffer #(
  parameter int BTB_IDX_W = 6
) (
  input  logic          clk,
  input  logic          rst,
  input  fe_pkg::addr_t lk_adr,
  input  logic          upd_valid,
  input  fe_pkg::addr_t upd_src,
  input  fe_pkg::addr_t upd_target,
  input  fe_pkg::kind_t upd_kind,
  output logic          btb_hit,
  output fe_pkg::addr_t btb_target,
  output fe_pkg::kind_t btb_kind
);

  localparam int ENTRIES = 1 << BTB_IDX_W;
  localparam int TAG_W   = fe_pkg::ADDR_W - fe_pkg::BLOCK_OFS_W - BTB_IDX_W;

  typedef logic [BTB_IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0]     tag_t;

  logic [ENTRIES-1:0] valid;
  tag_t               tag_mem    [ENTRIES];
  fe_pkg::addr_t      target_mem [ENTRIES];
  fe_pkg::kind_t      kind_mem   [ENTRIES];

  idx_t lk_idx;
  idx_t wr_idx;
  tag_t lk_tag;
  tag_t wr_tag;

  // index from the block bits, tag is everything above
  assign lk_idx = lk_adr[fe_pkg::BLOCK_OFS_W +: BTB_IDX_W];
  assign lk_tag = lk_adr[fe_pkg::ADDR_W-1 -: TAG_W];
  assign wr_idx = upd_src[fe_pkg::BLOCK_OFS_W +: BTB_IDX_W];
  assign wr_tag = upd_src[fe_pkg::ADDR_W-1 -: TAG_W];

  assign btb_hit    = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
  assign btb_target = target_mem[lk_idx];
  assign btb_kind   = kind_mem[lk_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (upd_valid) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_valid) begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= upd_target;
      kind_mem[wr_idx]   <= upd_kind;   // replaces whatever aliased here
    end
  end

endmodule

`default_nettype wire

/* hw/return_stack.sv */
// circular return-address stack
// calls push the fall-through address, returns pop it, oldest entry lost on overflow
`timescale 1ns/1ns
`default_nettype none

module return_stack #(
  parameter int RAS_DEPTH = 8
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  logic          pop,
  input  fe_pkg::addr_t push_adr,
  output fe_pkg::addr_t top
);

  localparam int PTR_W = $clog2(RAS_DEPTH);

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] ptr_up;
  fe_pkg::addr_t    mem [RAS_DEPTH];

  assign ptr_up = ptr + 1'b1;   // wraps
  assign top    = mem[ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (push) begin
      ptr <= ptr_up;
    end else if (pop) begin
      ptr <= ptr - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[ptr_up] <= push_adr;
  end

  // one fetch block is either a call or a return
  a_no_push_pop: assert property (@(posedge clk) disable iff (rst)
    !(push && pop));

endmodule

`default_nettype wire

/* hw/fetch_sequencer.sv */
// fetch pointer and global history, issues one Wishbone classic read per block
// next address comes from a pending redirect, the BTB with the direction
// predictor and return stack, or the next sequential block
`timescale 1ns/1ns
`default_nettype none

module fetch_sequencer #(
  parameter fe_pkg::addr_t RESET_IP = 32'h0000_1000
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           wb_ack,
  input  logic           btb_hit,
  input  fe_pkg::addr_t  btb_target,
  input  fe_pkg::kind_t  btb_kind,
  input  logic           pred_taken,
  input  fe_pkg::addr_t  ras_top,
  input  logic           redirect_valid,
  input  fe_pkg::addr_t  redirect_adr,
  input  fe_pkg::ghist_t redirect_ghist,
  output logic           wb_cyc,
  output logic           wb_stb,
  output fe_pkg::addr_t  wb_adr,
  output logic           fetch_pred_taken,
  output fe_pkg::ghist_t fetch_ghist,
  output logic           ras_push,
  output logic           ras_pop,
  output fe_pkg::addr_t  ras_push_adr
);

  fe_pkg::addr_t  pc;
  fe_pkg::ghist_t ghist;
  logic           fresh;      // first cycle of the current request
  logic           h_hit;
  logic           h_taken;
  fe_pkg::addr_t  h_target;
  fe_pkg::kind_t  h_kind;
  logic           l_hit;
  logic           l_taken;
  fe_pkg::addr_t  l_target;
  fe_pkg::kind_t  l_kind;
  logic           pend;
  fe_pkg::addr_t  pend_adr;
  fe_pkg::ghist_t pend_ghist;
  logic           accept;
  logic           redir_now;
  logic           is_cond;
  fe_pkg::addr_t  seq_adr;
  fe_pkg::addr_t  pred_adr;
  fe_pkg::addr_t  redir_adr;
  fe_pkg::ghist_t redir_ghist;

  assign accept = wb_stb && wb_ack;

  // retire training may move the lookup while a request waits, so
  // the answer seen in the first cycle is held until ack
  assign l_hit    = fresh ? btb_hit : h_hit;
  assign l_taken  = fresh ? pred_taken : h_taken;
  assign l_target = fresh ? btb_target : h_target;
  assign l_kind   = fresh ? btb_kind : h_kind;

  assign is_cond          = l_hit && (l_kind == fe_pkg::KIND_COND);
  assign fetch_pred_taken = l_hit && ((l_kind != fe_pkg::KIND_COND) || l_taken);

  assign seq_adr  = pc + fe_pkg::addr_t'(fe_pkg::FETCH_BYTES);
  assign pred_adr = !fetch_pred_taken ? seq_adr :
                    (l_kind == fe_pkg::KIND_RET) ? ras_top : l_target;

  // a redirect arriving on the ack cycle wins straight away
  assign redir_now   = redirect_valid || pend;
  assign redir_adr   = redirect_valid ? redirect_adr : pend_adr;
  assign redir_ghist = redirect_valid ? redirect_ghist : pend_ghist;

  assign ras_push     = accept && !redir_now && l_hit && (l_kind == fe_pkg::KIND_CALL);
  assign ras_pop      = accept && !redir_now && l_hit && (l_kind == fe_pkg::KIND_RET);
  assign ras_push_adr = seq_adr;

  assign wb_adr      = pc;
  assign fetch_ghist = ghist;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      pc     <= RESET_IP;
      ghist  <= '0;
      fresh  <= 1'b1;
      pend   <= 1'b0;
    end else begin
      wb_cyc <= 1'b1;   // back to back requests from here on
      wb_stb <= 1'b1;
      if (wb_stb) fresh <= wb_ack;
      if (accept && redir_now) begin
        pc    <= redir_adr;
        ghist <= redir_ghist;
        pend  <= 1'b0;
      end else begin
        if (accept) begin
          pc <= pred_adr;
          if (is_cond) ghist <= {ghist[fe_pkg::HIST_W-2:0], l_taken};
        end
        if (redirect_valid) pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_stb && fresh) begin
      h_hit    <= btb_hit;
      h_taken  <= pred_taken;
      h_target <= btb_target;
      h_kind   <= btb_kind;
    end
    if (redirect_valid) begin
      pend_adr   <= redirect_adr;   // newest redirect replaces an older one
      pend_ghist <= redirect_ghist;
    end
  end

  // the slave only acks a strobed request
  a_ack_stb: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_stb);

  a_hold: assert property (@(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(fetch_pred_taken) &&
                          $stable(fetch_ghist));

endmodule

`default_nettype wire

/* hw/frontend_top.sv */
// fetch front end top level
// retire resolution feeds the BTB, the direction tables and the sequencer,
// fetch requests leave on a Wishbone classic read master
`timescale 1ns/1ns
`default_nettype none

module frontend_top #(
  parameter fe_pkg::addr_t RESET_IP  = 32'h0000_1000,
  parameter int            BTB_IDX_W = 6,
  parameter int            PHT_IDX_W = 8,
  parameter int            RAS_DEPTH = 8
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           wb_ack,
  input  logic           ret_valid,
  input  fe_pkg::addr_t  ret_src,
  input  fe_pkg::addr_t  ret_target,
  input  fe_pkg::kind_t  ret_kind,
  input  fe_pkg::cond_t  ret_cond,
  input  fe_pkg::flags_t ret_flags,
  input  logic           ret_pred_taken,
  input  fe_pkg::addr_t  ret_pred_target,
  input  fe_pkg::ghist_t ret_ghist,
  output logic           wb_cyc,
  output logic           wb_stb,
  output fe_pkg::addr_t  wb_adr,
  output logic           fetch_pred_taken,
  output fe_pkg::ghist_t fetch_ghist
);

  logic           upd_valid;
  logic           trn_valid;
  fe_pkg::addr_t  upd_src;
  fe_pkg::addr_t  upd_target;
  fe_pkg::kind_t  upd_kind;
  fe_pkg::ghist_t upd_ghist;
  logic           upd_taken;
  logic           redirect_valid;
  fe_pkg::addr_t  redirect_adr;
  fe_pkg::ghist_t redirect_ghist;
  logic           btb_hit;
  fe_pkg::addr_t  btb_target;
  fe_pkg::kind_t  btb_kind;
  logic           pred_taken;
  logic           ras_push;
  logic           ras_pop;
  fe_pkg::addr_t  ras_push_adr;
  fe_pkg::addr_t  ras_top;

  branch_retire u_retire (
    .clk, .rst, .ret_valid, .ret_src, .ret_target, .ret_kind, .ret_cond, .ret_flags,
    .ret_pred_taken, .ret_pred_target, .ret_ghist,
    .upd_valid, .trn_valid, .upd_src, .upd_target, .upd_kind, .upd_ghist, .upd_taken,
    .redirect_valid, .redirect_adr, .redirect_ghist
  );

  // lookups run on the address and history of the request on the bus
  target_buffer #(.BTB_IDX_W(BTB_IDX_W)) u_btb (
    .clk, .rst, .lk_adr(wb_adr), .upd_valid, .upd_src, .upd_target, .upd_kind,
    .btb_hit, .btb_target, .btb_kind
  );

  dir_predictor #(.PHT_IDX_W(PHT_IDX_W)) u_dir (
    .clk, .rst, .lk_adr(wb_adr), .lk_ghist(fetch_ghist),
    .trn_valid, .upd_src, .upd_ghist, .upd_taken, .pred_taken
  );

  return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
    .clk, .rst, .push(ras_push), .pop(ras_pop), .push_adr(ras_push_adr), .top(ras_top)
  );

  fetch_sequencer #(.RESET_IP(RESET_IP)) u_seq (
    .clk, .rst, .wb_ack, .btb_hit, .btb_target, .btb_kind, .pred_taken, .ras_top,
    .redirect_valid, .redirect_adr, .redirect_ghist,
    .wb_cyc, .wb_stb, .wb_adr, .fetch_pred_taken, .fetch_ghist,
    .ras_push, .ras_pop, .ras_push_adr
  );

endmodule

`default_nettype wire

/* test/tb_frontend.sv */
// testbench for the fetch front end
// plays retire and expect records from test/fe_cases.txt against a Wishbone
// slave that acks after a random delay, then checks the accepted fetch addresses
`timescale 1ns/1ns
`default_nettype none

module tb_frontend;

  localparam int MAX_WORDS  = 1024;
  localparam int MAX_ACCEPT = 4096;
  localparam logic [31:0] REC_EXPECT = 32'h0;
  localparam logic [31:0] REC_RETIRE = 32'h1;
  localparam logic [31:0] REC_END    = 32'hf;

  logic           clk;
  logic           rst;
  logic           wb_ack;
  logic           wb_cyc;
  logic           wb_stb;
  fe_pkg::addr_t  wb_adr;
  logic           fetch_pred_taken;
  fe_pkg::ghist_t fetch_ghist;
  logic           ret_valid;
  fe_pkg::addr_t  ret_src;
  fe_pkg::addr_t  ret_target;
  fe_pkg::kind_t  ret_kind;
  fe_pkg::cond_t  ret_cond;
  fe_pkg::flags_t ret_flags;
  logic           ret_pred_taken;
  fe_pkg::addr_t  ret_pred_target;
  fe_pkg::ghist_t ret_ghist;

  logic [31:0]    words   [MAX_WORDS];
  fe_pkg::addr_t  adr_log [MAX_ACCEPT];
  logic           pt_log  [MAX_ACCEPT];
  fe_pkg::ghist_t gh_log  [MAX_ACCEPT];
  int             acc_cnt = 0;
  int             cyc_cnt = 0;
  int             limit   = 0;
  int             seed    = 54;
  int             wait_cnt;
  logic           held     = 1'b0;
  fe_pkg::addr_t  held_adr;
  logic           in_reset = 1'b0;

  frontend_top u_frontend_top (
    .clk, .rst, .wb_ack, .ret_valid, .ret_src, .ret_target, .ret_kind, .ret_cond,
    .ret_flags, .ret_pred_taken, .ret_pred_target, .ret_ghist,
    .wb_cyc, .wb_stb, .wb_adr, .fetch_pred_taken, .fetch_ghist
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // waits until request idx was accepted, then compares it
  task automatic check_fetch(input int idx, input logic [31:0] exp_adr,
                             input logic [31:0] exp_pt);
    while (acc_cnt <= idx) @(posedge clk);
    assert (adr_log[idx] == exp_adr) else
      abort_run($sformatf("[ERROR] wb_adr request %0d expected %h got %h",
                          idx, exp_adr, adr_log[idx]));
    if (exp_pt != 32'h2) begin   // 2 means unchecked
      assert (pt_log[idx] == exp_pt[0]) else
        abort_run($sformatf("[ERROR] fetch_pred_taken request %0d expected %h got %h",
                            idx, exp_pt[0], pt_log[idx]));
    end
  endtask

  // request idx must already be accepted
  task automatic check_history(input int idx, input fe_pkg::ghist_t exp_gh);
    assert (gh_log[idx] == exp_gh) else
      abort_run($sformatf("[ERROR] fetch_ghist request %0d expected %h got %h",
                          idx, exp_gh, gh_log[idx]));
  endtask

  // slave, ack after 0 to 3 wait cycles
  always @(posedge clk) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      wait_cnt <= 0;
    end else if (wb_stb && wb_ack) begin
      wb_ack   <= 1'b0;
      wait_cnt <= $random(seed) & 3;
    end else if (wb_stb) begin
      if (wait_cnt == 0) wb_ack <= 1'b1;
      else wait_cnt <= wait_cnt - 1;
    end
  end

  // bus monitor
  always @(posedge clk) begin
    if (rst) begin
      if (in_reset) begin
        assert (!wb_cyc && !wb_stb) else
          abort_run($sformatf("[ERROR] wb_cyc/wb_stb in reset expected 0/0 got %h/%h",
                              wb_cyc, wb_stb));
      end
      in_reset <= 1'b1;
      held     <= 1'b0;
    end else begin
      if (held) begin
        assert (wb_adr == held_adr) else
          abort_run($sformatf("[ERROR] wb_adr during wait expected %h got %h",
                              held_adr, wb_adr));
      end
      held     <= wb_stb && !wb_ack;
      held_adr <= wb_adr;
      if (wb_stb && wb_ack) begin
        adr_log[acc_cnt] <= wb_adr;
        pt_log[acc_cnt]  <= fetch_pred_taken;
        gh_log[acc_cnt]  <= fetch_ghist;
        acc_cnt          <= acc_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (limit > 0 && cyc_cnt >= limit) begin
      abort_run("timeout, the fetch requests stopped making progress");
    end
  end

  initial begin
    int i;
    int nrec;
    int anchor;
    logic first;
    fe_pkg::ghist_t redir_gh;
    rst             = 1'b1;
    wb_ack          = 1'b0;
    ret_valid       = 1'b0;
    ret_src         = '0;
    ret_target      = '0;
    ret_kind        = '0;
    ret_cond        = '0;
    ret_flags       = '0;
    ret_pred_taken  = 1'b0;
    ret_pred_target = '0;
    ret_ghist       = '0;
    $readmemh("test/fe_cases.txt", words);
    nrec = 0;
    i = 0;
    while (i < MAX_WORDS - 11 && words[i] != REC_END) begin
      i += (words[i] == REC_RETIRE) ? 11 : 4;
      nrec++;
    end
    limit = nrec * 40 + 256;   // plus the table sweep
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    anchor = 0;
    first = 1'b1;
    i = 0;
    while (words[i] != REC_END) begin
      if (words[i] == REC_RETIRE) begin
        if (first) begin
          repeat (260) @(posedge clk);   // counter sweep
          first = 1'b0;
        end
        // retire on an accept edge, so the redirect lands two requests later
        do @(posedge clk); while (!(wb_stb && wb_ack));
        anchor = acc_cnt;
        ret_valid       <= 1'b1;
        ret_src         <= words[i+1];
        ret_target      <= words[i+2];
        ret_kind        <= words[i+3][1:0];
        ret_cond        <= words[i+4][3:0];
        ret_flags       <= words[i+5][3:0];
        ret_pred_taken  <= words[i+6][0];
        ret_pred_target <= words[i+7];
        ret_ghist       <= words[i+8][15:0];
        @(posedge clk);
        ret_valid <= 1'b0;
        check_fetch(anchor + 2, words[i+9], words[i+10]);
        // a COND shifts in whether the redirect went to its target
        redir_gh = words[i+8][15:0];
        if (words[i+3][1:0] == fe_pkg::KIND_COND) begin
          redir_gh = {redir_gh[fe_pkg::HIST_W-2:0], words[i+9] == words[i+2]};
        end
        check_history(anchor + 2, redir_gh);
        i += 11;
      end else if (words[i] == REC_EXPECT) begin
        check_fetch(anchor + words[i+1], words[i+2], words[i+3]);
        i += 4;
      end else begin
        abort_run("unknown record type in the case file");
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* test/fe_cases.txt */
// retire: 1 src target kind cond flags pred_taken pred_target ghist exp_adr exp_pt
// expect: 0 n adr pt (n counts accepts from the last retire, pt 2 unchecked), end: f
0 0 00001000 0
0 1 00001020 0
0 2 00001040 0
0 3 00001060 0
1 00002000 00009000 0 0 0 0 00000000 0000 00009000 0
1 00002020 00009100 0 1 0 1 00000000 0000 00002040 0
1 00002040 00009200 0 2 4 0 00000000 0000 00009200 0
1 00002060 00009300 0 3 4 1 00000000 0000 00002080 0
1 00002080 00009400 0 4 8 0 00000000 0000 00009400 0
1 000020a0 00009500 0 5 0 0 00000000 0000 00009500 0
1 000020c0 00009600 0 6 0 1 00000000 0000 000020e0 0
1 000020e0 00009700 0 7 2 1 00000000 0000 00002100 0
1 00002100 00009800 0 8 1 0 00000000 0000 00009800 0
1 00002120 00009900 0 9 1 1 00000000 0000 00002140 0
1 00002140 00009a00 0 a 2 0 00000000 0000 00009a00 0
1 00002160 00009b00 0 b 3 0 00000000 0000 00009b00 0
1 00002180 00009c00 0 c 4 0 00000000 0000 00009c00 0
1 000021a0 00009d00 0 d 1 1 00000000 0000 000021c0 0
1 000021c0 00009e00 0 e 0 1 00000000 0000 000021e0 0
1 000021e0 00009f00 0 f 8 1 00000000 0000 00002200 0
1 00004400 00004c00 0 0 0 0 00000000 0a05 00004c00 0
1 00004400 00004c00 0 0 0 0 00000000 0a05 00004c00 0
1 00006600 00004400 1 0 0 0 00000000 0a05 00004400 1
0 3 00004c00 0
1 00004800 00004900 0 1 0 1 00000000 0000 00004820 0
1 00006640 00004800 1 0 0 0 00000000 0000 00004800 0
0 3 00004820 0
1 00005700 00007000 2 0 0 0 00000000 0000 00007000 0
1 00007040 00005720 3 0 0 0 00000000 0000 00005720 0
1 00006680 00005700 1 0 0 0 00000000 0000 00005700 1
0 3 00007000 0
0 4 00007020 0
0 5 00007040 1
0 6 00005720 0
f

/* src.f */
hw/fe_pkg.sv
hw/branch_retire.sv
hw/dir_predictor.sv
hw/target_buffer.sv
hw/return_stack.sv
hw/fetch_sequencer.sv
hw/frontend_top.sv
test/tb_frontend.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - hw/fe_pkg.sv
  - hw/branch_retire.sv
  - hw/dir_predictor.sv
  - hw/target_buffer.sv
  - hw/return_stack.sv
  - hw/fetch_sequencer.sv
  - hw/frontend_top.sv
  - target: test
    files:
      - test/tb_frontend.sv
